/* design/ccu_pkg.sv */
package ccu_pkg;

  // Kind of snoop sent to the caches of a domain
  typedef enum logic {
    SnoopRead       = 1'b0, // Dirty data back and line left clean
    SnoopInvalidate = 1'b1  // Line removed from the cache
  } snoop_op_e;

  // Defaults for the top level widths
  localparam int unsigned DefaultAddrWidth = 16;
  localparam int unsigned DefaultDataWidth = 32; // One word per line

endpackage

/* design/ccu_stream_reg.sv */
`timescale 1ns/100ps

module ccu_stream_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_i,
  input  logic     valid_i,
  output logic     ready_o,
  input  payload_t data_i,
  output logic     valid_o,
  input  logic     ready_i,
  output payload_t data_o
);

  logic     valid_q;
  logic     valid_d;
  logic     ready_q;
  payload_t data_q;

  // Full when data stays or new data comes in
  assign valid_d = valid_q ? !ready_i : (valid_i && ready_q);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_q <= 1'b0;
      ready_q <= 1'b0; // Low for one cycle out of reset
    end else begin
      valid_q <= valid_d;
      ready_q <= !valid_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i && ready_q) data_q <= data_i;
  end

  assign ready_o = ready_q;
  assign valid_o = valid_q;
  assign data_o  = data_q;

  a_data_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    (valid_o && !ready_i) |=> $stable(data_o));

endmodule

/* design/ccu_arbiter.sv */
`timescale 1ns/100ps

module ccu_arbiter #(
  parameter int unsigned NumPorts  = 0,
  parameter int unsigned AddrWidth = 0,
  parameter int unsigned DataWidth = 0
) (
  input  logic                               clk_i,
  input  logic                               rst_i,
  input  logic [NumPorts-1:0]                slv_valid_i,
  output logic [NumPorts-1:0]                slv_ready_o,
  input  logic [NumPorts-1:0]                slv_write_i,
  input  logic [NumPorts-1:0][AddrWidth-1:0] slv_addr_i,
  input  logic [NumPorts-1:0][DataWidth-1:0] slv_wdata_i,
  output logic                               valid_o,
  input  logic                               ready_i,
  output logic [$clog2(NumPorts)-1:0]        idx_o,
  output logic                               write_o,
  output logic [AddrWidth-1:0]               addr_o,
  output logic [DataWidth-1:0]               wdata_o,
  input  logic                               txn_done_i
);

  localparam int unsigned IdxWidth = $clog2(NumPorts);

  logic [IdxWidth-1:0] last_q;
  logic [IdxWidth-1:0] winner;
  logic [NumPorts-1:0] gnt;
  logic                locked_q;

  // Nearest requester after the last winner overrides the farther ones
  always_comb begin
    int cand;
    winner = last_q;
    gnt    = '0;
    for (int k = NumPorts; k > 0; k--) begin
      cand = int'(last_q) + k;
      if (cand >= int'(NumPorts)) cand = cand - int'(NumPorts);
      if (slv_valid_i[cand]) winner = IdxWidth'(cand);
    end
    if (|slv_valid_i) gnt[winner] = 1'b1;
  end

  assign valid_o     = !locked_q && |slv_valid_i;
  assign slv_ready_o = (!locked_q && ready_i) ? gnt : '0;

  assign idx_o   = winner;
  assign write_o = slv_write_i[winner];
  assign addr_o  = slv_addr_i[winner];
  assign wdata_o = slv_wdata_i[winner];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      locked_q <= 1'b0;
      last_q   <= IdxWidth'(NumPorts - 1); // Port 0 goes first
    end else if (valid_o && ready_i) begin
      locked_q <= 1'b1;
      last_q   <= winner;
    end else if (txn_done_i) begin
      locked_q <= 1'b0;
    end
  end

  a_gnt_onehot: assert property (@(posedge clk_i) disable iff (rst_i)
    $onehot0(slv_ready_o));

endmodule

/* design/ccu_snoop_interconnect.sv */
`timescale 1ns/100ps

module ccu_snoop_interconnect #(
  parameter int unsigned NumPorts  = 0,
  parameter int unsigned AddrWidth = 0,
  parameter int unsigned DataWidth = 0
) (
  input  logic                                  clk_i,
  input  logic                                  rst_i,
  input  logic                                  snp_valid_i,
  output logic                                  snp_ready_o,
  input  ccu_pkg::snoop_op_e                    snp_op_i,
  input  logic [AddrWidth-1:0]                  snp_addr_i,
  input  logic [NumPorts-1:0]                   snp_mask_i,
  output logic                                  snp_done_o,
  output logic                                  snp_dirty_o,
  output logic [DataWidth-1:0]                  snp_data_o,
  output logic [NumPorts-1:0]                   snoop_valid_o,
  input  logic [NumPorts-1:0]                   snoop_ready_i,
  output ccu_pkg::snoop_op_e [NumPorts-1:0]     snoop_op_o,
  output logic [NumPorts-1:0][AddrWidth-1:0]    snoop_addr_o,
  input  logic [NumPorts-1:0]                   snoop_resp_valid_i,
  output logic [NumPorts-1:0]                   snoop_resp_ready_o,
  input  logic [NumPorts-1:0]                   snoop_resp_dirty_i,
  input  logic [NumPorts-1:0][DataWidth-1:0]    snoop_resp_data_i
);

  import ccu_pkg::*;

  localparam int unsigned IdxWidth = $clog2(NumPorts);

  logic                 busy_q;
  logic                 issue;
  logic [NumPorts-1:0]  mask_q;
  logic [NumPorts-1:0]  acc_pend_q; // Still to accept the snoop
  logic [NumPorts-1:0]  rsp_pend_q; // Still to respond
  logic [NumPorts-1:0]  req_hs;
  logic [NumPorts-1:0]  rsp_hs;
  snoop_op_e            op_q;
  logic [AddrWidth-1:0] addr_q;
  logic                 dirty_q;
  logic                 dirty_d;
  logic [DataWidth-1:0] data_q;
  logic [DataWidth-1:0] data_d;
  logic [IdxWidth-1:0]  src_q;
  logic [IdxWidth-1:0]  src_d;

  assign snp_ready_o = !busy_q;
  assign issue       = snp_valid_i && !busy_q;
  assign snp_done_o  = busy_q && acc_pend_q == '0 && rsp_pend_q == '0;
  assign snp_dirty_o = dirty_q;
  assign snp_data_o  = data_q;

  assign snoop_valid_o      = acc_pend_q;
  assign snoop_resp_ready_o = rsp_pend_q & ~acc_pend_q;
  assign req_hs             = snoop_valid_o & snoop_ready_i;
  assign rsp_hs             = snoop_resp_valid_i & snoop_resp_ready_o;

  for (genvar p = 0; p < NumPorts; p++) begin : gen_fanout
    assign snoop_op_o[p]   = op_q;
    assign snoop_addr_o[p] = addr_q;
  end

  // Lowest dirty responder wins, also across cycles
  always_comb begin
    dirty_d = dirty_q;
    data_d  = data_q;
    src_d   = src_q;
    for (int i = 0; i < NumPorts; i++) begin
      if (rsp_hs[i] && snoop_resp_dirty_i[i] && (!dirty_d || i < int'(src_d))) begin
        dirty_d = 1'b1;
        data_d  = snoop_resp_data_i[i];
        src_d   = IdxWidth'(i);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      busy_q     <= 1'b0;
      acc_pend_q <= '0;
      rsp_pend_q <= '0;
    end else if (issue) begin
      busy_q     <= 1'b1;
      acc_pend_q <= snp_mask_i;
      rsp_pend_q <= snp_mask_i;
    end else begin
      acc_pend_q <= acc_pend_q & ~req_hs;
      rsp_pend_q <= rsp_pend_q & ~rsp_hs;
      if (snp_done_o) busy_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (issue) begin
      op_q    <= snp_op_i;
      addr_q  <= snp_addr_i;
      mask_q  <= snp_mask_i;
      dirty_q <= 1'b0;
    end else begin
      dirty_q <= dirty_d;
      data_q  <= data_d;
      src_q   <= src_d;
    end
  end

  a_in_mask: assert property (@(posedge clk_i) disable iff (rst_i)
    (snoop_valid_o & ~mask_q) == '0);

endmodule

/* design/ccu_master_path.sv */
`timescale 1ns/100ps

module ccu_master_path #(
  parameter int unsigned NumPorts  = 0,
  parameter int unsigned AddrWidth = 0,
  parameter int unsigned DataWidth = 0
) (
  input  logic                              clk_i,
  input  logic                              rst_i,
  input  logic                              req_valid_i,
  output logic                              req_ready_o,
  input  logic [$clog2(NumPorts)-1:0]       req_idx_i,
  input  logic                              req_write_i,
  input  logic [AddrWidth-1:0]              req_addr_i,
  input  logic [DataWidth-1:0]              req_wdata_i,
  input  logic [NumPorts-1:0][NumPorts-1:0] domain_mask_i,
  output logic                              txn_done_o,
  output logic                              snp_valid_o,
  input  logic                              snp_ready_i,
  output ccu_pkg::snoop_op_e                snp_op_o,
  output logic [AddrWidth-1:0]              snp_addr_o,
  output logic [NumPorts-1:0]               snp_mask_o,
  input  logic                              snp_done_i,
  input  logic                              snp_dirty_i,
  input  logic [DataWidth-1:0]              snp_data_i,
  output logic                              mst_valid_o,
  input  logic                              mst_ready_i,
  output logic                              mst_write_o,
  output logic [AddrWidth-1:0]              mst_addr_o,
  output logic [DataWidth-1:0]              mst_wdata_o,
  input  logic                              mem_valid_i,
  output logic                              mem_ready_o,
  input  logic [DataWidth-1:0]              mem_data_i,
  output logic [NumPorts-1:0]               slv_rvalid_o,
  input  logic [NumPorts-1:0]               slv_rready_i,
  output logic [DataWidth-1:0]              slv_rdata_o
);

  import ccu_pkg::*;

  localparam int unsigned IdxWidth = $clog2(NumPorts);

  typedef enum logic [2:0] {
    Idle,
    SnpReq,  // Snoop offered to the interconnect
    SnpWait, // Waiting for the merged result
    MemRd,
    MemRsp,
    MemWr,   // Write or dirty writeback
    Resp
  } state_e;

  state_e               state_q;
  state_e               state_d;
  logic [IdxWidth-1:0]  idx_q;
  logic                 write_q;
  logic [AddrWidth-1:0] addr_q;
  logic [NumPorts-1:0]  mask_q;
  logic [DataWidth-1:0] data_q; // Result register
  logic                 accept;
  logic                 rsp_hs;

  assign accept = state_q == Idle && req_valid_i;
  assign rsp_hs = state_q == Resp && slv_rready_i[idx_q];

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      Idle:    if (req_valid_i) state_d = SnpReq;
      SnpReq:  if (snp_ready_i) state_d = SnpWait;
      SnpWait: begin
        if (snp_done_i) begin
          if (write_q || snp_dirty_i) state_d = MemWr;
          else state_d = MemRd;
        end
      end
      MemRd:   if (mst_ready_i) state_d = MemRsp;
      MemRsp:  if (mem_valid_i) state_d = Resp;
      MemWr:   if (mst_ready_i) state_d = Resp;
      Resp:    if (rsp_hs) state_d = Idle;
      default: state_d = Idle;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= Idle;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      idx_q   <= req_idx_i;
      write_q <= req_write_i;
      addr_q  <= req_addr_i;
      mask_q  <= domain_mask_i[req_idx_i] & ~(NumPorts'(1) << req_idx_i); // Never self
      data_q  <= req_wdata_i; // Echoed back on a write
    end
    if (state_q == SnpWait && snp_done_i && !write_q && snp_dirty_i) data_q <= snp_data_i;
    if (mem_valid_i && mem_ready_o) data_q <= mem_data_i;
  end

  assign req_ready_o = state_q == Idle;

  assign snp_valid_o = state_q == SnpReq;
  assign snp_op_o    = write_q ? SnoopInvalidate : SnoopRead;
  assign snp_addr_o  = addr_q;
  assign snp_mask_o  = mask_q;

  // Dirty read writes back the snooped line
  assign mst_valid_o = state_q == MemRd || state_q == MemWr;
  assign mst_write_o = state_q == MemWr;
  assign mst_addr_o  = addr_q;
  assign mst_wdata_o = data_q;
  assign mem_ready_o = state_q == MemRsp;

  for (genvar p = 0; p < NumPorts; p++) begin : gen_rvalid
    assign slv_rvalid_o[p] = state_q == Resp && idx_q == IdxWidth'(p);
  end
  assign slv_rdata_o = data_q;
  assign txn_done_o  = rsp_hs;

  a_no_mem_in_snoop: assert property (@(posedge clk_i) disable iff (rst_i)
    (state_q == SnpReq || state_q == SnpWait) |-> !mst_valid_o);

endmodule

/* design/ccu_top.sv */
`timescale 1ns/100ps

module ccu_top #(
  parameter int unsigned NumPorts  = 2,
  parameter int unsigned AddrWidth = ccu_pkg::DefaultAddrWidth,
  parameter int unsigned DataWidth = ccu_pkg::DefaultDataWidth
) (
  input  logic                                clk_i,
  input  logic                                rst_i,
  input  logic [NumPorts-1:0]                 slv_valid_i,
  output logic [NumPorts-1:0]                 slv_ready_o,
  input  logic [NumPorts-1:0]                 slv_write_i,
  input  logic [NumPorts-1:0][AddrWidth-1:0]  slv_addr_i,
  input  logic [NumPorts-1:0][DataWidth-1:0]  slv_wdata_i,
  output logic [NumPorts-1:0]                 slv_rvalid_o,
  input  logic [NumPorts-1:0]                 slv_rready_i,
  output logic [NumPorts-1:0][DataWidth-1:0]  slv_rdata_o,
  input  logic [NumPorts-1:0][NumPorts-1:0]   domain_mask_i,
  output logic [NumPorts-1:0]                 snoop_valid_o,
  input  logic [NumPorts-1:0]                 snoop_ready_i,
  output ccu_pkg::snoop_op_e [NumPorts-1:0]   snoop_op_o,
  output logic [NumPorts-1:0][AddrWidth-1:0]  snoop_addr_o,
  input  logic [NumPorts-1:0]                 snoop_resp_valid_i,
  output logic [NumPorts-1:0]                 snoop_resp_ready_o,
  input  logic [NumPorts-1:0]                 snoop_resp_dirty_i,
  input  logic [NumPorts-1:0][DataWidth-1:0]  snoop_resp_data_i,
  output logic                                mst_valid_o,
  input  logic                                mst_ready_i,
  output logic                                mst_write_o,
  output logic [AddrWidth-1:0]                mst_addr_o,
  output logic [DataWidth-1:0]                mst_wdata_o,
  input  logic                                mst_rvalid_i,
  output logic                                mst_rready_o,
  input  logic [DataWidth-1:0]                mst_rdata_i
);

  import ccu_pkg::*;

  localparam int unsigned IdxWidth = $clog2(NumPorts);

  typedef logic [DataWidth-1:0] data_t;

  typedef struct packed {
    logic [IdxWidth-1:0]  idx;
    logic                 write;
    logic [AddrWidth-1:0] addr;
    data_t                data;
  } req_t;

  req_t      arb_req;
  req_t      req;
  logic      arb_valid;
  logic      arb_ready;
  logic      req_valid;
  logic      req_ready;
  logic      txn_done;
  logic      snp_valid;
  logic      snp_ready;
  snoop_op_e snp_op;
  logic [AddrWidth-1:0] snp_addr;
  logic [NumPorts-1:0]  snp_mask;
  logic      snp_done;
  logic      snp_dirty;
  data_t     snp_data;
  logic      mem_valid;
  logic      mem_ready;
  data_t     mem_data;
  data_t     resp_data;

  assign slv_rdata_o = {NumPorts{resp_data}}; // Same word on every port

  ccu_arbiter #(
    .NumPorts    (NumPorts),
    .AddrWidth   (AddrWidth),
    .DataWidth   (DataWidth)
  ) i_arbiter (
    .clk_i,
    .rst_i,
    .slv_valid_i,
    .slv_ready_o,
    .slv_write_i,
    .slv_addr_i,
    .slv_wdata_i,
    .valid_o     (arb_valid),
    .ready_i     (arb_ready),
    .idx_o       (arb_req.idx),
    .write_o     (arb_req.write),
    .addr_o      (arb_req.addr),
    .wdata_o     (arb_req.data),
    .txn_done_i  (txn_done)
  );

  ccu_stream_reg #(
    .payload_t (req_t)
  ) i_req_reg (
    .clk_i,
    .rst_i,
    .valid_i   (arb_valid),
    .ready_o   (arb_ready),
    .data_i    (arb_req),
    .valid_o   (req_valid),
    .ready_i   (req_ready),
    .data_o    (req)
  );

  ccu_master_path #(
    .NumPorts      (NumPorts),
    .AddrWidth     (AddrWidth),
    .DataWidth     (DataWidth)
  ) i_master_path (
    .clk_i,
    .rst_i,
    .req_valid_i   (req_valid),
    .req_ready_o   (req_ready),
    .req_idx_i     (req.idx),
    .req_write_i   (req.write),
    .req_addr_i    (req.addr),
    .req_wdata_i   (req.data),
    .domain_mask_i,
    .txn_done_o    (txn_done),
    .snp_valid_o   (snp_valid),
    .snp_ready_i   (snp_ready),
    .snp_op_o      (snp_op),
    .snp_addr_o    (snp_addr),
    .snp_mask_o    (snp_mask),
    .snp_done_i    (snp_done),
    .snp_dirty_i   (snp_dirty),
    .snp_data_i    (snp_data),
    .mst_valid_o,
    .mst_ready_i,
    .mst_write_o,
    .mst_addr_o,
    .mst_wdata_o,
    .mem_valid_i   (mem_valid),
    .mem_ready_o   (mem_ready),
    .mem_data_i    (mem_data),
    .slv_rvalid_o,
    .slv_rready_i,
    .slv_rdata_o   (resp_data)
  );

  ccu_snoop_interconnect #(
    .NumPorts    (NumPorts),
    .AddrWidth   (AddrWidth),
    .DataWidth   (DataWidth)
  ) i_snoop_interconnect (
    .clk_i,
    .rst_i,
    .snp_valid_i (snp_valid),
    .snp_ready_o (snp_ready),
    .snp_op_i    (snp_op),
    .snp_addr_i  (snp_addr),
    .snp_mask_i  (snp_mask),
    .snp_done_o  (snp_done),
    .snp_dirty_o (snp_dirty),
    .snp_data_o  (snp_data),
    .snoop_valid_o,
    .snoop_ready_i,
    .snoop_op_o,
    .snoop_addr_o,
    .snoop_resp_valid_i,
    .snoop_resp_ready_o,
    .snoop_resp_dirty_i,
    .snoop_resp_data_i
  );

  // Memory read data register
  ccu_stream_reg #(
    .payload_t (data_t)
  ) i_mem_reg (
    .clk_i,
    .rst_i,
    .valid_i   (mst_rvalid_i),
    .ready_o   (mst_rready_o),
    .data_i    (mst_rdata_i),
    .valid_o   (mem_valid),
    .ready_i   (mem_ready),
    .data_o    (mem_data)
  );

endmodule

/* test/tb_ccu_top.sv */
`timescale 1ns/100ps

module tb_ccu_top;

  import ccu_pkg::*;

  localparam int unsigned NumPorts  = 3;
  localparam int unsigned AddrWidth = 16;
  localparam int unsigned DataWidth = 32;

  logic                                clk_i;
  logic                                rst_i;
  logic [NumPorts-1:0]                 slv_valid_i;
  logic [NumPorts-1:0]                 slv_ready_o;
  logic [NumPorts-1:0]                 slv_write_i;
  logic [NumPorts-1:0][AddrWidth-1:0]  slv_addr_i;
  logic [NumPorts-1:0][DataWidth-1:0]  slv_wdata_i;
  logic [NumPorts-1:0]                 slv_rvalid_o;
  logic [NumPorts-1:0]                 slv_rready_i;
  logic [NumPorts-1:0][DataWidth-1:0]  slv_rdata_o;
  logic [NumPorts-1:0][NumPorts-1:0]   domain_mask_i;
  logic [NumPorts-1:0]                 snoop_valid_o;
  logic [NumPorts-1:0]                 snoop_ready_i;
  snoop_op_e [NumPorts-1:0]            snoop_op_o;
  logic [NumPorts-1:0][AddrWidth-1:0]  snoop_addr_o;
  logic [NumPorts-1:0]                 snoop_resp_valid_i;
  logic [NumPorts-1:0]                 snoop_resp_ready_o;
  logic [NumPorts-1:0]                 snoop_resp_dirty_i;
  logic [NumPorts-1:0][DataWidth-1:0]  snoop_resp_data_i;
  logic                                mst_valid_o;
  logic                                mst_ready_i;
  logic                                mst_write_o;
  logic [AddrWidth-1:0]                mst_addr_o;
  logic [DataWidth-1:0]                mst_wdata_o;
  logic                                mst_rvalid_i;
  logic                                mst_rready_o;
  logic [DataWidth-1:0]                mst_rdata_i;

  logic [31:0] stim_rng;
  logic [31:0] stall_rng;
  logic [31:0] mem_q [logic [15:0]];  // Written lines only
  bit          dirty_q [logic [17:0]]; // Key is port and address
  logic [31:0] line_q [logic [17:0]];
  int          mst_cnt;
  logic        mst_wr_seen;
  logic [15:0] mst_addr_seen;
  logic [31:0] mst_data_seen;
  logic        rd_busy;
  logic [31:0] rd_data;
  int          snp_cnt [NumPorts];
  logic        snp_op_seen [NumPorts];
  logic [15:0] snp_addr_seen [NumPorts];
  logic [NumPorts-1:0] rsp_busy;
  logic [NumPorts-1:0] rsp_dirty;
  logic [31:0] rsp_data [NumPorts];
  int          last_winner;
  logic [31:0] r;

  ccu_top #(
    .NumPorts  (NumPorts),
    .AddrWidth (AddrWidth),
    .DataWidth (DataWidth)
  ) ccu_top_inst (.*);

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_stim();
    stim_rng = xorshift(stim_rng);
    return stim_rng;
  endfunction

  function automatic logic [31:0] mem_read(input logic [15:0] a);
    if (mem_q.exists(a)) return mem_q[a];
    return {a ^ 16'hc3a5, a}; // Fill from the whole address
  endfunction

  function automatic logic [17:0] line_key(input int q, input logic [15:0] a);
    return {2'(q), a};
  endfunction

  function automatic logic [15:0] addr_of(input int i);
    return 16'h4000 | (16'(i) << 4);
  endfunction

  function automatic int next_winner(input logic [NumPorts-1:0] pending, input int last);
    for (int k = 1; k <= NumPorts; k++) begin
      if (pending[(last + k) % NumPorts]) return (last + k) % NumPorts;
    end
    return -1;
  endfunction

  task automatic fail_stop(input string msg);
    $display("%s", msg);
    $display("*** TEST FAILED ***");
    $fatal(1);
  endtask

  task automatic check_val(input string name, input logic [31:0] act, input logic [31:0] exp);
    if (act !== exp) fail_stop($sformatf("FAIL %s: got 0x%h, expected 0x%h", name, act, exp));
  endtask

  // Local write in cache c leaves it the only owner
  task automatic make_dirty(input int c, input logic [15:0] a, input logic [31:0] d);
    for (int q = 0; q < NumPorts; q++) dirty_q.delete(line_key(q, a));
    dirty_q[line_key(c, a)] = 1'b1;
    line_q[line_key(c, a)]  = d;
  endtask

  // Called at the grant edge, before any snoop can start
  task automatic finish_txn(input int p, input logic wr, input logic [15:0] a,
                            input logic [31:0] d);
    logic [NumPorts-1:0] mask;
    logic                exp_dirty;
    logic [31:0]         exp_line;
    logic [31:0]         exp_rdata;
    logic [31:0]         got;
    int                  t;
    exp_dirty = 1'b0;
    exp_line  = '0;
    for (int q = 0; q < NumPorts; q++) begin
      mask[q] = domain_mask_i[p][q] && q != p;
      if (mask[q] && !exp_dirty && dirty_q.exists(line_key(q, a))) begin
        exp_dirty = 1'b1;
        exp_line  = line_q[line_key(q, a)];
      end
    end
    if (wr) exp_rdata = d;
    else if (exp_dirty) exp_rdata = exp_line;
    else exp_rdata = mem_read(a);
    mst_cnt = 0;
    for (int q = 0; q < NumPorts; q++) snp_cnt[q] = 0;
    last_winner = p;
    @(negedge clk_i);
    slv_valid_i[p] = 1'b0;
    t = 0;
    @(posedge clk_i);
    while (!(slv_rvalid_o[p] && slv_rready_i[p])) begin
      t++;
      if (t > 1000) fail_stop($sformatf("Timeout waiting for the response on port %0d", p));
      @(posedge clk_i);
    end
    got = slv_rdata_o[p];
    check_val("slv_rvalid_o", 32'(slv_rvalid_o), 32'(NumPorts'(1) << p));
    check_val("slv_rdata_o", got, exp_rdata);
    check_val("mst_valid_o handshakes", mst_cnt, 1);
    check_val("mst_write_o", mst_wr_seen, wr || exp_dirty);
    check_val("mst_addr_o", mst_addr_seen, a);
    if (wr || exp_dirty) check_val("mst_wdata_o", mst_data_seen, wr ? d : exp_line);
    for (int q = 0; q < NumPorts; q++) begin
      check_val($sformatf("snoop_valid_o[%0d] handshakes", q), snp_cnt[q], mask[q]);
      if (mask[q]) begin
        check_val($sformatf("snoop_op_o[%0d]", q), snp_op_seen[q], wr);
        check_val($sformatf("snoop_addr_o[%0d]", q), snp_addr_seen[q], a);
      end
    end
    if (wr) dirty_q.delete(line_key(p, a)); // Own copy now matches memory
  endtask

  task automatic run_txn(input int p, input logic wr, input logic [15:0] a,
                         input logic [31:0] d);
    int t;
    @(negedge clk_i);
    slv_valid_i[p] = 1'b1;
    slv_write_i[p] = wr;
    slv_addr_i[p]  = a;
    slv_wdata_i[p] = d;
    t = 0;
    @(posedge clk_i);
    while (!slv_ready_o[p]) begin
      t++;
      if (t > 100) fail_stop($sformatf("Timeout waiting for a grant on port %0d", p));
      @(posedge clk_i);
    end
    finish_txn(p, wr, a, d);
  endtask

  // All ports request together and the grants rotate
  task automatic run_all_ports();
    logic [NumPorts-1:0] pending;
    int                  g;
    int                  t;
    @(negedge clk_i);
    for (int p = 0; p < NumPorts; p++) begin
      slv_valid_i[p] = 1'b1;
      slv_write_i[p] = 1'b0;
      slv_addr_i[p]  = addr_of(p + 4);
    end
    pending = '1;
    while (pending != '0) begin
      t = 0;
      @(posedge clk_i);
      while (slv_ready_o == '0) begin
        t++;
        if (t > 100) fail_stop("Timeout waiting for a grant with all ports requesting");
        @(posedge clk_i);
      end
      g = 0;
      for (int p = 0; p < NumPorts; p++) if (slv_ready_o[p]) g = p;
      check_val("granted port", g, next_winner(pending, last_winner));
      pending[g] = 1'b0;
      finish_txn(g, 1'b0, addr_of(g + 4), '0);
    end
  endtask

  always @(negedge clk_i) begin
    stall_rng   = xorshift(stall_rng);
    mst_ready_i = stall_rng[1:0] != 2'b00;
    for (int q = 0; q < NumPorts; q++) begin
      snoop_ready_i[q]      = stall_rng[4 + 2*q +: 2] != 2'b00;
      slv_rready_i[q]       = stall_rng[12 + 2*q +: 2] != 2'b00;
      snoop_resp_valid_i[q] = rsp_busy[q];
      snoop_resp_dirty_i[q] = rsp_dirty[q];
      snoop_resp_data_i[q]  = rsp_data[q];
    end
    mst_rvalid_i = rd_busy;
    mst_rdata_i  = rd_data;
  end

  // Memory and cache models react to handshakes
  always @(posedge clk_i) begin
    if (!rst_i) begin
      if (mst_valid_o && mst_ready_i) begin
        mst_cnt++;
        mst_wr_seen   = mst_write_o;
        mst_addr_seen = mst_addr_o;
        mst_data_seen = mst_wdata_o;
        if (mst_write_o) begin
          mem_q[mst_addr_o] = mst_wdata_o;
        end else begin
          rd_busy = 1'b1;
          rd_data = mem_read(mst_addr_o);
        end
      end
      if (mst_rvalid_i && mst_rready_o) rd_busy = 1'b0;
      for (int q = 0; q < NumPorts; q++) begin
        if (snoop_valid_o[q] && snoop_ready_i[q]) begin
          snp_cnt[q]++;
          snp_op_seen[q]   = snoop_op_o[q];
          snp_addr_seen[q] = snoop_addr_o[q];
          rsp_dirty[q]     = dirty_q.exists(line_key(q, snoop_addr_o[q]));
          rsp_data[q]      = rsp_dirty[q] ? line_q[line_key(q, snoop_addr_o[q])] : '0;
          dirty_q.delete(line_key(q, snoop_addr_o[q])); // Clean or gone either way
          rsp_busy[q]      = 1'b1;
        end
        if (snoop_resp_valid_i[q] && snoop_resp_ready_o[q]) rsp_busy[q] = 1'b0;
      end
    end
  end

  initial begin
    rst_i              = 1'b1;
    slv_valid_i        = '0;
    slv_write_i        = '0;
    slv_addr_i         = '0;
    slv_wdata_i        = '0;
    slv_rready_i       = '0;
    domain_mask_i      = {NumPorts{3'b111}};
    snoop_ready_i      = '0;
    snoop_resp_valid_i = '0;
    snoop_resp_dirty_i = '0;
    snoop_resp_data_i  = '0;
    mst_ready_i        = 1'b0;
    mst_rvalid_i       = 1'b0;
    mst_rdata_i        = '0;
    stim_rng           = 32'd48359;
    stall_rng          = xorshift(32'd48359);
    rd_busy            = 1'b0;
    rd_data            = '0;
    rsp_busy           = '0;
    rsp_dirty          = '0;
    mst_cnt            = 0;
    last_winner        = NumPorts - 1;
    for (int q = 0; q < NumPorts; q++) begin
      snp_cnt[q]  = 0;
      rsp_data[q] = '0;
    end
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    check_val("outputs in reset", {slv_ready_o, slv_rvalid_o, snoop_valid_o,
              snoop_resp_ready_o, mst_valid_o, mst_rready_o}, '0);
    rst_i = 1'b0;

    // Clean read, dirty read with writeback, then write
    run_txn(0, 1'b0, addr_of(0), '0);
    make_dirty(2, addr_of(1), 32'hdead_0001);
    run_txn(0, 1'b0, addr_of(1), '0);
    run_txn(1, 1'b0, addr_of(1), '0);
    make_dirty(1, addr_of(2), 32'hbeef_0002);
    run_txn(2, 1'b1, addr_of(2), 32'h1234_5678);
    run_txn(0, 1'b0, addr_of(2), '0);

    // Port 2 sits outside the domain of ports 0 and 1
    @(negedge clk_i);
    domain_mask_i[0] = 3'b011;
    domain_mask_i[1] = 3'b011;
    domain_mask_i[2] = 3'b100;
    make_dirty(2, addr_of(3), 32'h0bad_0003);
    run_txn(0, 1'b0, addr_of(3), '0);
    run_txn(1, 1'b1, addr_of(3), 32'h5555_aaaa);

    @(negedge clk_i);
    domain_mask_i = {NumPorts{3'b111}};
    run_all_ports();
    run_all_ports();

    @(negedge clk_i);
    domain_mask_i[0] = 3'b101;
    domain_mask_i[1] = 3'b011;
    domain_mask_i[2] = 3'b111;
    for (int n = 0; n < 400; n++) begin
      r = next_stim();
      if (r[1:0] == 2'b00) make_dirty(int'(r[7:4]) % NumPorts, addr_of(int'(r[22:20])),
                                      next_stim());
      run_txn(int'(r[15:8]) % NumPorts, r[16], addr_of(int'(r[19:17])), next_stim());
    end

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

/* ccu_top.f */
design/ccu_pkg.sv
design/ccu_stream_reg.sv
design/ccu_arbiter.sv
design/ccu_snoop_interconnect.sv
design/ccu_master_path.sv
design/ccu_top.sv
test/tb_ccu_top.sv

/* Bender.yml */
package:
  name: ccu

sources:
  - design/ccu_pkg.sv
  - design/ccu_stream_reg.sv
  - design/ccu_arbiter.sv
  - design/ccu_snoop_interconnect.sv
  - design/ccu_master_path.sv
  - design/ccu_top.sv
  - target: test
    files:
      - test/tb_ccu_top.sv
